// ==== Bender.yml ====
package:
  name: rsa_core

sources:
  - files:
      - rtl/rsa_pkg.sv
      - rtl/mont_mul.sv
      - rtl/mod_prep.sv
      - rtl/mod_exp.sv
      - rtl/rsa_apb_regs.sv
      - rtl/rsa_core_top.sv

  - target: test
    files:
      - tests/rsa_core_checker.sv
      - tests/rsa_core_tb.sv

// ==== filelist.f ====
rtl/rsa_pkg.sv
rtl/mont_mul.sv
rtl/mod_prep.sv
rtl/mod_exp.sv
rtl/rsa_apb_regs.sv
rtl/rsa_core_top.sv
tests/rsa_core_checker.sv
tests/rsa_core_tb.sv

// ==== rtl/mod_exp.sv ====
`timescale 1ns/1ps
`default_nettype none

module mod_exp
    import rsa_pkg::*;
#(
    parameter int WIDTH = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_start,
    input  wire logic [WIDTH-1:0] i_n,
    input  wire logic [WIDTH-1:0] i_e,
    input  wire logic [WIDTH-1:0] i_x,
    output logic      [WIDTH-1:0] o_y,
    output logic                  o_done
);
    localparam int CW = $clog2(WIDTH);

    mexp_state_t      state_r, state_w;
    logic [WIDTH-1:0] acc_r, acc_w;    // Plain-domain accumulator.
    logic [WIDTH-1:0] base_r, base_w;  // Montgomery-domain base.
    logic [WIDTH-1:0] e_r, e_w;
    logic [CW-1:0]    cnt_r, cnt_w;
    logic             prep_start_r, prep_start_w;
    logic             mul_start;
    logic [WIDTH-1:0] prep_xr;
    logic             prep_done;
    logic [WIDTH-1:0] mul_p;
    logic [WIDTH-1:0] sqr_p;
    logic             mul_done;
    logic             sqr_done;
    logic             step_done;

    assign step_done = mul_done & sqr_done;
    assign o_y       = acc_r;
    assign o_done    = (state_r == DONE);

    always_comb begin
        state_w      = state_r;
        acc_w        = acc_r;
        base_w       = base_r;
        e_w          = e_r;
        cnt_w        = cnt_r;
        prep_start_w = 1'b0;
        mul_start    = 1'b0;
        case (state_r)
            IDLE: begin
                if (i_start) begin
                    state_w      = PREP;
                    acc_w        = WIDTH'(1);
                    e_w          = i_e;
                    cnt_w        = '0;
                    prep_start_w = 1'b1;
                end
            end
            PREP: begin
                if (prep_done) begin
                    state_w   = STEP;
                    base_w    = prep_xr;
                    mul_start = 1'b1;  // First pass starts with no gap.
                end
            end
            STEP: begin
                if (step_done) begin
                    if (e_r[0]) begin
                        acc_w = mul_p;
                    end
                    base_w = sqr_p;
                    e_w    = e_r >> 1;
                    cnt_w  = cnt_r + 1'b1;
                    if (cnt_r == CW'(WIDTH - 1)) begin
                        state_w = DONE;
                    end else begin
                        mul_start = 1'b1;
                    end
                end
            end
            DONE: begin
                state_w = IDLE;
            end
            default: begin
                state_w = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r      <= IDLE;
            cnt_r        <= '0;
            prep_start_r <= 1'b0;
        end else begin
            state_r      <= state_w;
            cnt_r        <= cnt_w;
            prep_start_r <= prep_start_w;
        end
    end

    always_ff @(posedge i_clk) begin
        acc_r  <= acc_w;
        base_r <= base_w;
        e_r    <= e_w;
    end

    mod_prep #(.WIDTH(WIDTH)) u_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start_r),
        .i_x     (i_x),
        .i_n     (i_n),
        .o_xr    (prep_xr),
        .o_done  (prep_done)
    );

    // Operands come from the next-state values so a pass starts on the done cycle.
    mont_mul #(.WIDTH(WIDTH)) u_mul (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_a     (acc_w),
        .i_b     (base_w),
        .i_n     (i_n),
        .o_p     (mul_p),
        .o_done  (mul_done)
    );

    mont_mul #(.WIDTH(WIDTH)) u_sqr (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_a     (base_w),
        .i_b     (base_w),
        .i_n     (i_n),
        .o_p     (sqr_p),
        .o_done  (sqr_done)
    );

endmodule

`default_nettype wire

// ==== rtl/mod_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

module mod_prep #(
    parameter int WIDTH = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_start,
    input  wire logic [WIDTH-1:0] i_x,
    input  wire logic [WIDTH-1:0] i_n,
    output logic      [WIDTH-1:0] o_xr,
    output logic                  o_done
);
    localparam int CW = $clog2(WIDTH);

    logic [WIDTH-1:0] v_r, v_w;
    logic [WIDTH-1:0] n_r, n_w;
    logic [WIDTH:0]   dbl;
    logic [WIDTH:0]   red;
    logic [CW-1:0]    cnt_r, cnt_w;
    logic             run_r, run_w;
    logic             done_r, done_w;

    assign dbl    = {v_r, 1'b0};
    assign red    = dbl - {1'b0, n_r};
    assign o_xr   = v_r;
    assign o_done = done_r;

    always_comb begin
        v_w    = v_r;
        n_w    = n_r;
        cnt_w  = cnt_r;
        run_w  = run_r;
        done_w = 1'b0;
        if (run_r) begin
            v_w   = (dbl >= {1'b0, n_r}) ? red[WIDTH-1:0] : dbl[WIDTH-1:0];  // Stays below N.
            cnt_w = cnt_r + 1'b1;
            if (cnt_r == CW'(WIDTH - 1)) begin
                run_w  = 1'b0;
                done_w = 1'b1;
            end
        end else if (i_start) begin
            v_w   = i_x;
            n_w   = i_n;
            cnt_w = '0;
            run_w = 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cnt_r  <= '0;
            run_r  <= 1'b0;
            done_r <= 1'b0;
        end else begin
            cnt_r  <= cnt_w;
            run_r  <= run_w;
            done_r <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        v_r <= v_w;
        n_r <= n_w;
    end

endmodule

`default_nettype wire

// ==== rtl/mont_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module mont_mul #(
    parameter int WIDTH = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_start,
    input  wire logic [WIDTH-1:0] i_a,
    input  wire logic [WIDTH-1:0] i_b,
    input  wire logic [WIDTH-1:0] i_n,
    output logic      [WIDTH-1:0] o_p,
    output logic                  o_done
);
    localparam int CW = $clog2(WIDTH);

    logic [WIDTH+1:0] acc_r, acc_w;
    logic [WIDTH-1:0] a_r, a_w;
    logic [WIDTH-1:0] b_r, b_w;
    logic [WIDTH-1:0] n_r, n_w;
    logic [CW-1:0]    cnt_r, cnt_w;
    logic             run_r, run_w;
    logic             sub_r, sub_w;
    logic             done_r, done_w;

    // One radix-2 Montgomery step. The sum stays below 4N.
    function automatic logic [WIDTH+1:0] mont_step(
        input logic [WIDTH+1:0] acc,
        input logic             bit_a,
        input logic [WIDTH-1:0] b,
        input logic [WIDTH-1:0] n
    );
        logic [WIDTH+1:0] t;
        t = acc;
        if (bit_a) begin
            t = t + {2'b00, b};
        end
        if (t[0]) begin
            t = t + {2'b00, n};
        end
        return t >> 1;
    endfunction

    assign o_p    = acc_r[WIDTH-1:0];
    assign o_done = done_r;

    always_comb begin
        acc_w  = acc_r;
        a_w    = a_r;
        b_w    = b_r;
        n_w    = n_r;
        cnt_w  = cnt_r;
        run_w  = run_r;
        sub_w  = sub_r;
        done_w = 1'b0;
        if (run_r) begin
            acc_w = mont_step(acc_r, a_r[0], b_r, n_r);
            a_w   = a_r >> 1;
            cnt_w = cnt_r + 1'b1;
            if (cnt_r == CW'(WIDTH - 1)) begin
                run_w = 1'b0;
                sub_w = 1'b1;
            end
        end else if (sub_r) begin
            if (acc_r >= {2'b00, n_r}) begin
                acc_w = acc_r - {2'b00, n_r};
            end
            sub_w  = 1'b0;
            done_w = 1'b1;
        end else if (i_start) begin
            // Bit 0 is handled on the start edge itself.
            acc_w = mont_step('0, i_a[0], i_b, i_n);
            a_w   = i_a >> 1;
            b_w   = i_b;
            n_w   = i_n;
            cnt_w = CW'(1);
            run_w = 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cnt_r  <= '0;
            run_r  <= 1'b0;
            sub_r  <= 1'b0;
            done_r <= 1'b0;
        end else begin
            cnt_r  <= cnt_w;
            run_r  <= run_w;
            sub_r  <= sub_w;
            done_r <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        acc_r <= acc_w;
        a_r   <= a_w;
        b_r   <= b_w;
        n_r   <= n_w;
    end

endmodule

`default_nettype wire

// ==== rtl/rsa_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_apb_regs
    import rsa_pkg::*;
#(
    parameter int WIDTH = 256
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_psel,
    input  wire logic             i_penable,
    input  wire logic             i_pwrite,
    input  wire apb_addr_t        i_paddr,
    input  wire apb_data_t        i_pwdata,
    output apb_data_t             o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,
    output logic                  o_start,
    output logic      [WIDTH-1:0] o_n,
    output logic      [WIDTH-1:0] o_e,
    output logic      [WIDTH-1:0] o_x,
    input  wire logic [WIDTH-1:0] i_y,
    input  wire logic             i_done
);
    localparam int NW = WIDTH / 32;

    logic [WIDTH-1:0] n_r, e_r, x_r, y_r;
    logic             start_r, busy_r, done_r;
    logic             acc_phase;
    logic             wr_ok;
    logic [5:0]       idx;
    logic             in_range;
    logic             sel_ctrl, sel_status, sel_n, sel_e, sel_x, sel_y;
    logic             err;

    assign acc_phase  = i_psel & i_penable;
    assign idx        = i_paddr[7:2];
    assign in_range   = (i_paddr[1:0] == 2'b00) && (int'(idx) < NW);
    assign sel_ctrl   = (i_paddr == ADDR_CTRL);
    assign sel_status = (i_paddr == ADDR_STATUS);
    assign sel_n      = in_range && (i_paddr[11:8] == ADDR_N_BASE[11:8]);
    assign sel_e      = in_range && (i_paddr[11:8] == ADDR_E_BASE[11:8]);
    assign sel_x      = in_range && (i_paddr[11:8] == ADDR_X_BASE[11:8]);
    assign sel_y      = in_range && (i_paddr[11:8] == ADDR_Y_BASE[11:8]);

    always_comb begin
        err = 1'b0;
        if (!(sel_ctrl | sel_status | sel_n | sel_e | sel_x | sel_y)) begin
            err = 1'b1;
        end else if (i_pwrite && (sel_y || sel_status)) begin
            err = 1'b1;  // Read-only registers.
        end else if (i_pwrite && busy_r) begin
            err = 1'b1;  // Operands and control are locked while busy.
        end
    end

    assign o_pready  = 1'b1;  // No wait states.
    assign o_pslverr = acc_phase & err;
    assign wr_ok     = acc_phase & i_pwrite & ~err;

    always_comb begin
        o_prdata = '0;
        if (acc_phase && !i_pwrite && !err) begin
            if (sel_status) begin
                o_prdata = {30'b0, done_r, busy_r};
            end else if (sel_n) begin
                o_prdata = n_r[int'(idx) * 32 +: 32];
            end else if (sel_e) begin
                o_prdata = e_r[int'(idx) * 32 +: 32];
            end else if (sel_x) begin
                o_prdata = x_r[int'(idx) * 32 +: 32];
            end else if (sel_y) begin
                o_prdata = y_r[int'(idx) * 32 +: 32];
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            start_r <= 1'b0;
            busy_r  <= 1'b0;
            done_r  <= 1'b0;
            y_r     <= '0;
        end else begin
            start_r <= 1'b0;
            if (i_done) begin
                y_r    <= i_y;
                busy_r <= 1'b0;
                done_r <= 1'b1;
            end else if (wr_ok && sel_ctrl && i_pwdata[0]) begin
                start_r <= 1'b1;
                busy_r  <= 1'b1;
                done_r  <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_ok && sel_n) begin
            n_r[int'(idx) * 32 +: 32] <= i_pwdata;
        end
        if (wr_ok && sel_e) begin
            e_r[int'(idx) * 32 +: 32] <= i_pwdata;
        end
        if (wr_ok && sel_x) begin
            x_r[int'(idx) * 32 +: 32] <= i_pwdata;
        end
    end

    assign o_start = start_r;
    assign o_n     = n_r;
    assign o_e     = e_r;
    assign o_x     = x_r;

endmodule

`default_nettype wire

// ==== rtl/rsa_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_core_top
    import rsa_pkg::*;
#(
    parameter int WIDTH = 256
) (
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire logic      i_psel,
    input  wire logic      i_penable,
    input  wire logic      i_pwrite,
    input  wire apb_addr_t i_paddr,
    input  wire apb_data_t i_pwdata,
    output apb_data_t      o_prdata,
    output logic           o_pready,
    output logic           o_pslverr
);
    logic             exp_start;
    logic             exp_done;
    logic [WIDTH-1:0] op_n, op_e, op_x;
    logic [WIDTH-1:0] res_y;

    rsa_apb_regs #(.WIDTH(WIDTH)) u_regs (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_start   (exp_start),
        .o_n       (op_n),
        .o_e       (op_e),
        .o_x       (op_x),
        .i_y       (res_y),
        .i_done    (exp_done)
    );

    mod_exp #(.WIDTH(WIDTH)) u_exp (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (exp_start),
        .i_n     (op_n),
        .i_e     (op_e),
        .i_x     (op_x),
        .o_y     (res_y),
        .o_done  (exp_done)
    );

endmodule

`default_nettype wire

// ==== rtl/rsa_pkg.sv ====
`default_nettype none

package rsa_pkg;

    typedef logic [11:0] apb_addr_t;  // APB byte address.
    typedef logic [31:0] apb_data_t;

    // Register map.
    localparam apb_addr_t ADDR_CTRL   = 12'h000;  // Bit 0 is start.
    localparam apb_addr_t ADDR_STATUS = 12'h004;  // Bit 0 busy, bit 1 done.
    localparam apb_addr_t ADDR_N_BASE = 12'h100;
    localparam apb_addr_t ADDR_E_BASE = 12'h200;
    localparam apb_addr_t ADDR_X_BASE = 12'h300;
    localparam apb_addr_t ADDR_Y_BASE = 12'h400;

    typedef enum logic [1:0] {
        IDLE,
        PREP,
        STEP,
        DONE
    } mexp_state_t;

endpackage

`default_nettype wire

// ==== tests/rsa_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_core_checker (
    input wire logic i_clk,
    input wire logic i_rst,
    input wire logic i_psel,
    input wire logic i_penable,
    input wire logic i_pready,
    input wire logic i_busy,
    input wire logic i_done,
    input wire logic i_start
);
    int fail_count = 0;  // Count of failed assertions.

    property p_no_wait_states;
        @(posedge i_clk) disable iff (i_rst)
            (i_psel && i_penable) |-> i_pready;
    endproperty

    // Busy and done are exclusive.
    property p_busy_done_exclusive;
        @(posedge i_clk) disable iff (i_rst)
            !(i_busy && i_done);
    endproperty

    property p_start_single_cycle;
        @(posedge i_clk) disable iff (i_rst)
            i_start |=> !i_start;
    endproperty

    property p_start_from_idle;
        @(posedge i_clk) disable iff (i_rst)
            i_start |-> !$past(i_busy);
    endproperty

    assert property (p_no_wait_states) else begin
        $error("pready low in an APB access phase");
        fail_count++;
    end
    assert property (p_busy_done_exclusive) else begin
        $error("busy and done set together");
        fail_count++;
    end
    assert property (p_start_single_cycle) else begin
        $error("start pulse longer than one cycle");
        fail_count++;
    end
    assert property (p_start_from_idle) else begin
        $error("start pulse while engine was busy");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== tests/rsa_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_core_tb
    import rsa_pkg::*;
();
    localparam int W          = 64;
    localparam int NW         = W / 32;
    localparam int POLL_LIMIT = 4000;  // Status reads before giving up.

    logic         i_clk;
    logic         i_rst;
    logic         i_psel;
    logic         i_penable;
    logic         i_pwrite;
    apb_addr_t    i_paddr;
    apb_data_t    i_pwdata;
    apb_data_t    o_prdata;
    logic         o_pready;
    logic         o_pslverr;

    string        lbl_q[$];
    logic [W-1:0] got_q[$];
    logic [W-1:0] exp_q[$];
    string        cmp_lbl;
    logic [W-1:0] cmp_got;
    logic [W-1:0] cmp_exp;
    int           check_errors;
    int           errors_at_start;
    int           tests_passed;
    int           tests_failed;
    logic [W-1:0] cur_n;
    logic [W-1:0] cur_y;

    rsa_core_top #(.WIDTH(W)) dut0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    bind rsa_core_top rsa_core_checker u_chk (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pready  (o_pready),
        .i_busy    (u_regs.busy_r),
        .i_done    (u_regs.done_r),
        .i_start   (exp_start)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    // Square-and-multiply, exponent scanned from the LSB.
    function automatic logic [W-1:0] mod_pow(
        input logic [W-1:0] x,
        input logic [W-1:0] e,
        input logic [W-1:0] n
    );
        logic [2*W-1:0] m;
        logic [2*W-1:0] r;
        logic [2*W-1:0] b;
        m = {{W{1'b0}}, n};
        r = 1 % m;
        b = {{W{1'b0}}, x} % m;
        for (int i = 0; i < W; i++) begin
            if (e[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[W-1:0];
    endfunction

    always @(posedge i_clk) begin
        while (got_q.size() > 0) begin
            cmp_lbl = lbl_q.pop_front();
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            assert (cmp_got === cmp_exp) else begin
                $display("mismatch at %0t ns: %s got %h expected %h",
                         $time, cmp_lbl, cmp_got, cmp_exp);
                check_errors++;
            end
        end
    end

    task automatic check(input string label, input logic [W-1:0] got, input logic [W-1:0] exp);
        lbl_q.push_back(label);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(negedge i_clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge i_clk);
        i_penable = 1'b1;  // Access phase.
        #1;
        rdata = o_prdata;
        err   = o_pslverr;
        @(negedge i_clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic write_check(input apb_addr_t addr, input apb_data_t data,
                               input logic exp_err, input string label);
        apb_data_t rdata;
        logic      err;
        apb_xfer(addr, 1'b1, data, rdata, err);
        check({label, " pslverr"}, err, exp_err);
    endtask

    task automatic read_check(input apb_addr_t addr, input apb_data_t exp, input string label);
        apb_data_t rdata;
        logic      err;
        apb_xfer(addr, 1'b0, '0, rdata, err);
        check(label, rdata, exp);
        check({label, " pslverr"}, err, 1'b0);
    endtask

    task automatic write_operand(input apb_addr_t base, input logic [W-1:0] v);
        for (int i = 0; i < NW; i++) begin
            write_check(base + apb_addr_t'(4 * i), v[32*i +: 32], 1'b0, "operand write");
        end
    endtask

    task automatic rand_operands(output logic [W-1:0] n, output logic [W-1:0] e,
                                 output logic [W-1:0] x);
        n        = {$urandom, $urandom};
        n[W-1]   = 1'b1;
        n[0]     = 1'b1;  // Modulus must be odd.
        e        = {$urandom, $urandom};
        x        = {$urandom, $urandom} % n;
    endtask

    task automatic start_exp(input logic [W-1:0] n, input logic [W-1:0] e,
                             input logic [W-1:0] x);
        write_operand(ADDR_N_BASE, n);
        write_operand(ADDR_E_BASE, e);
        write_operand(ADDR_X_BASE, x);
        write_check(ADDR_CTRL, 32'h1, 1'b0, "start write");
        cur_n = n;
    endtask

    task automatic finish_exp(input logic [W-1:0] exp, input string label);
        apb_data_t    rdata;
        logic         err;
        logic         done;
        int           polls;
        logic [W-1:0] y;
        done  = 1'b0;
        polls = 0;
        while (!done && polls < POLL_LIMIT) begin
            apb_xfer(ADDR_STATUS, 1'b0, '0, rdata, err);
            done = rdata[1];
            polls++;
        end
        if (!done) begin
            $display("timeout in %s: done bit not set after %0d status reads", label, polls);
            check_errors++;
        end
        for (int i = 0; i < NW; i++) begin
            apb_xfer(ADDR_Y_BASE + apb_addr_t'(4 * i), 1'b0, '0, rdata, err);
            y[32*i +: 32] = rdata;
        end
        check(label, y, exp);
        read_check(ADDR_STATUS, 32'h2, "status after done");
        cur_y = y;
    endtask

    task automatic finish_test(input string name);
        int waits;
        int total;
        waits = 0;
        while (got_q.size() != 0 && waits < 8) begin
            @(negedge i_clk);
            waits++;
        end
        if (got_q.size() != 0) begin
            $display("compare process did not drain its queue in %s", name);
            check_errors++;
        end
        total = check_errors + dut0.u_chk.fail_count;  // Bound assertions count too.
        if (total == errors_at_start) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s", name);
            tests_failed++;
        end
        errors_at_start = total;
    endtask

    initial begin
        logic [W-1:0] n;
        logic [W-1:0] e;
        logic [W-1:0] x;
        void'($urandom(32'h5897));
        i_rst           = 1'b1;
        i_psel          = 1'b0;
        i_penable       = 1'b0;
        i_pwrite        = 1'b0;
        i_paddr         = '0;
        i_pwdata        = '0;
        check_errors    = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        read_check(ADDR_STATUS, 32'h0, "status after reset");
        for (int i = 0; i < NW; i++) begin
            read_check(ADDR_Y_BASE + apb_addr_t'(4 * i), 32'h0, "result after reset");
        end
        finish_test("reset values");

        for (int t = 0; t < 20; t++) begin
            rand_operands(n, e, x);
            start_exp(n, e, x);
            finish_exp(mod_pow(x, e, n), "random result");
            finish_test($sformatf("random operands %0d", t));
        end

        rand_operands(n, e, x);
        start_exp(n, '0, x);
        finish_exp(W'(1), "E=0 result");
        start_exp(n, W'(1), x);
        finish_exp(x, "E=1 result");
        start_exp(n, e | W'(1), '0);
        finish_exp('0, "X=0 result");
        start_exp(n, '1, x);
        finish_exp(mod_pow(x, '1, n), "all-ones E result");
        finish_test("edge exponents");

        // Word index 2 lies beyond a 64-bit operand.
        write_check(ADDR_N_BASE + 12'h008, 32'hdead_beef, 1'b1, "unmapped write");
        for (int i = 0; i < NW; i++) begin
            read_check(ADDR_N_BASE + apb_addr_t'(4 * i), cur_n[32*i +: 32], "N kept");
        end
        write_check(ADDR_Y_BASE, ~cur_y[31:0], 1'b1, "result write");
        read_check(ADDR_Y_BASE, cur_y[31:0], "result kept");
        write_check(ADDR_STATUS, 32'h0, 1'b1, "status write");
        read_check(ADDR_STATUS, 32'h2, "status kept");
        rand_operands(n, e, x);
        start_exp(n, e, x);
        write_check(ADDR_N_BASE, ~n[31:0], 1'b1, "operand write while busy");
        read_check(ADDR_N_BASE, n[31:0], "N kept while busy");
        write_check(ADDR_CTRL, 32'h1, 1'b1, "second start");
        read_check(ADDR_STATUS, 32'h1, "status while busy");
        finish_exp(mod_pow(x, e, n), "result after refused accesses");
        finish_test("slave errors");

        rand_operands(n, e, x);
        start_exp(n, e, x);
        finish_exp(mod_pow(x, e, n), "first result");
        rand_operands(n, e, x);
        start_exp(n, e, x);
        read_check(ADDR_STATUS, 32'h1, "status right after restart");
        finish_exp(mod_pow(x, e, n), "second result");
        finish_test("back to back");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
